/* list.f */
common/mcs51_pkg.sv
core/mcs51_fetch.sv
core/mcs51_decode.sv
core/mcs51_alu.sv
core/mcs51_data_regs.sv
source/mcs51_core.sv
verif/tb_clock.sv
verif/tb_mcs51.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, then scan the log for the failure line
rm -f sim.log
verilator --binary --assert --top-module tb_mcs51 -f list.f -o tb_mcs51 &&
  ./obj_dir/tb_mcs51 > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

/* verif/tb_mcs51.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcs51;
  localparam int IRAM_SIZE  = 128;
  localparam int IMG_BYTES  = 16;
  localparam int ARITH_RUNS = 18;
  localparam int LOGIC_RUNS = 12;
  localparam int DJNZ_RUNS  = 4;
  localparam int COND_RUNS  = 9;
  localparam int LJMP_RUNS  = 2;
  localparam int SFR_RUNS   = 4;
  localparam int RUN_COUNT  = ARITH_RUNS + LOGIC_RUNS + DJNZ_RUNS + COND_RUNS + LJMP_RUNS +
                              SFR_RUNS + 3; // Two reset runs and the timing run
  localparam int RUN_CYCLES = 100; // Longest program is a DJNZ loop of 8 passes
  localparam int WATCHDOG_CYCLES = RUN_COUNT * (RUN_CYCLES + 20) + 100;
  localparam logic [15:0] LFSR_SEED = 16'd30652;

  logic        clk;
  logic        reset_n;
  logic        restart;
  logic [15:0] code_addr;
  logic [7:0]  code_rdata;
  logic [7:0]  sfr_raddr;
  logic [7:0]  sfr_rdata;
  logic [7:0]  sfr_waddr;
  logic [7:0]  sfr_wdata;
  logic        sfr_we;

  logic [7:0]  code_mem [256];
  logic [7:0]  sfr_table [256];
  logic [15:0] lfsr;
  int          cycle;
  int          error_count;
  int          check_count;
  logic [7:0]  wr_addr [$];
  logic [7:0]  wr_data [$];
  int          wr_cycle [$];
  logic [7:0]  exp_addr [$];
  logic [7:0]  exp_data [$];

  tb_clock i_clock (
    .restart (restart),
    .clk     (clk),
    .reset_n (reset_n)
  );

  mcs51_core #(
    .IRAM_SIZE (IRAM_SIZE)
  ) i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .code_addr  (code_addr),
    .code_rdata (code_rdata),
    .sfr_raddr  (sfr_raddr),
    .sfr_rdata  (sfr_rdata),
    .sfr_waddr  (sfr_waddr),
    .sfr_wdata  (sfr_wdata),
    .sfr_we     (sfr_we)
  );

  assign code_rdata = code_mem[code_addr[7:0]]; // Programs stay below 100h
  assign sfr_rdata  = sfr_table[sfr_raddr];

  always @(posedge clk) cycle <= cycle + 1;

  // Write strobe log, sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n && sfr_we) begin
      wr_addr.push_back(sfr_waddr);
      wr_data.push_back(sfr_wdata);
      wr_cycle.push_back(cycle);
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic random_byte(output logic [7:0] value);
    for (int i = 0; i < 8; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  task automatic compare_value(input string name, input string what, input int expected,
                               input int actual);
    check_count++;
    assert (expected == actual) else begin
      error_count++;
      $display("Fail %s %s: expected %0h, actual %0h", name, what, expected, actual);
    end
  endtask

  task automatic require(input logic cond, input string name, input string text);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("Error in %s: %s", name, text);
    end
  endtask

  task automatic clear_code();
    @(posedge clk);
    #1;
    for (int a = 0; a < 256; a++) code_mem[a[7:0]] = 8'h00;
  endtask

  // First byte sits in the top used byte of the image
  task automatic place_code(input logic [7:0] base, input int len,
                            input logic [IMG_BYTES*8-1:0] image);
    for (int i = 0; i < len; i++) code_mem[base + i[7:0]] = image[(len - 1 - i) * 8 +: 8];
  endtask

  task automatic reset_core(input string name);
    @(posedge clk);
    #1 restart = 1'b1;
    @(posedge clk);
    #1 restart = 1'b0;
    do begin
      @(negedge clk);
      require(code_addr == 16'h0000, name, "code address is not 0000h during or after reset");
      require(!sfr_we, name, "SFR write strobe is high during or after reset");
    end while (!reset_n);
    wr_addr.delete();
    wr_data.delete();
    wr_cycle.delete();
  endtask

  task automatic run_to_halt(input logic [15:0] end_addr, input string name);
    int waited;
    waited = 0;
    while (code_addr != end_addr && waited < RUN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    require(code_addr == end_addr, name, "program never reached its final loop");
    repeat (4) @(negedge clk); // Last write strobe lands here
  endtask

  task automatic expect_write(input logic [7:0] addr, input logic [7:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic verify_writes(input string name);
    compare_value(name, "write count", exp_addr.size(), wr_addr.size());
    for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++) begin
      compare_value(name, $sformatf("write %0d address", i), int'(exp_addr[i]), int'(wr_addr[i]));
      compare_value(name, $sformatf("write %0d data", i), int'(exp_data[i]), int'(wr_data[i]));
    end
    exp_addr.delete();
    exp_data.delete();
  endtask

  // 8051 flag rules, SUBB borrows into CY and AC
  task automatic arith_model(input logic [7:0] op, input logic [7:0] x, input logic [7:0] y,
                             input logic carry, output logic [7:0] result,
                             output logic [7:0] psw_val);
    int   cin;
    int   full;
    int   low;
    int   signed_val;
    logic cy;
    logic ac;
    logic ov;
    cin = (op == 8'h24) ? 0 : int'(carry);
    if (op == 8'h94) begin
      full       = int'(x) - int'(y) - cin;
      low        = int'(x[3:0]) - int'(y[3:0]) - cin;
      signed_val = int'($signed(x)) - int'($signed(y)) - cin;
      cy         = (full < 0);
      ac         = (low < 0);
    end else begin
      full       = int'(x) + int'(y) + cin;
      low        = int'(x[3:0]) + int'(y[3:0]) + cin;
      signed_val = int'($signed(x)) + int'($signed(y)) + cin;
      cy         = (full > 255);
      ac         = (low > 15);
    end
    ov      = (signed_val > 127) || (signed_val < -128);
    result  = full[7:0];
    psw_val = {cy, ac, 3'b000, ov, 1'b0, ^full[7:0]}; // Bank 0, P is odd parity
  endtask

  task automatic reset_behavior();
    string name;
    name = "reset";
    clear_code();
    place_code(8'h00, 4, 128'({8'h74, 8'h5A, 8'hF5, 8'h90}));
    place_code(8'h04, 3, 128'({8'hF5, 8'h91, 8'h80}));
    place_code(8'h07, 1, 128'({8'hFE}));
    reset_core(name);
    repeat (4) @(negedge clk); // Stop in the middle of the program
    reset_core(name);
    run_to_halt(16'h0006, name);
    expect_write(8'h90, 8'h5A);
    expect_write(8'h91, 8'h5A);
    verify_writes(name);
  endtask

  task automatic arith_flags();
    logic [7:0] op;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] r;
    logic [7:0] result;
    logic [7:0] psw_val;
    string      name;
    for (int i = 0; i < ARITH_RUNS; i++) begin
      op = (i % 3 == 0) ? 8'h24 : ((i % 3 == 1) ? 8'h34 : 8'h94);
      random_byte(x);
      random_byte(y);
      random_byte(r);
      name = $sformatf("arith %02h x=%02h y=%02h cy=%0b", op, x, y, r[0]);
      clear_code();
      place_code(8'h00, 13, 128'({r[0] ? 8'hD3 : 8'hC3, 8'h74, x, op, y, 8'hF5, 8'h90,
                                  8'hE5, 8'hD0, 8'hF5, 8'h91, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt(16'h000B, name);
      arith_model(op, x, y, r[0], result, psw_val);
      expect_write(8'h90, result);
      expect_write(8'h91, psw_val);
      verify_writes(name);
    end
  endtask

  task automatic logic_banks();
    logic [7:0] op;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] result;
    string      name;
    for (int i = 0; i < LOGIC_RUNS; i++) begin
      random_byte(x);
      random_byte(y);
      case (i % 3)
        0:       begin op = 8'h5B; result = y & x; end
        1:       begin op = 8'h4B; result = y | x; end
        default: begin op = 8'h6B; result = y ^ x; end
      endcase
      name = $sformatf("logic %02h r3=%02h a=%02h", op, x, y);
      clear_code();
      // Bank 1 selected, so R3 is RAM address 0Bh
      place_code(8'h00, 16, 128'({8'h75, 8'hD0, 8'h08, 8'h7B, x, 8'h74, y, op,
                                  8'hF5, 8'h90, 8'hE5, 8'h0B, 8'hF5, 8'h91, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt(16'h000E, name);
      expect_write(8'h90, result);
      expect_write(8'h91, x);
      verify_writes(name);
    end
  endtask

  task automatic djnz_loop();
    logic [7:0] r;
    logic [7:0] n;
    string      name;
    for (int i = 0; i < DJNZ_RUNS; i++) begin
      random_byte(r);
      n    = 8'd1 + {5'd0, r[2:0]};
      name = $sformatf("djnz n=%0d", n);
      clear_code();
      // DJNZ at 04h goes back 4 bytes from 06h to the write at 02h
      place_code(8'h00, 8, 128'({8'h7A, n, 8'hF5, 8'h90, 8'hDA, 8'hFC, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt(16'h0006, name);
      for (int k = 0; k < int'(n); k++) expect_write(8'h90, 8'h00);
      verify_writes(name);
    end
  endtask

  task automatic cond_branches();
    logic [7:0] v;
    logic [7:0] r;
    logic [7:0] cond;
    logic       carry;
    logic       taken;
    string      name;
    for (int i = 0; i < COND_RUNS; i++) begin
      random_byte(v);
      random_byte(r);
      carry = r[0];
      case (i)
        0:       begin cond = 8'h60; v = 8'h00; end
        1:       begin cond = 8'h60; v = v | 8'h01; end
        2:       begin cond = 8'h70; v = 8'h00; end
        3:       begin cond = 8'h70; v = v | 8'h01; end
        4:       begin cond = 8'h40; carry = 1'b1; end
        5:       begin cond = 8'h50; carry = 1'b0; end
        6:       begin cond = 8'h40; carry = 1'b0; end
        7:       begin cond = 8'h50; carry = 1'b1; end
        default: cond = 8'h80;
      endcase
      case (cond)
        8'h60:   taken = (v == 8'h00);
        8'h70:   taken = (v != 8'h00);
        8'h40:   taken = carry;
        8'h50:   taken = !carry;
        default: taken = 1'b1;
      endcase
      name = $sformatf("branch %02h acc=%02h cy=%0b", cond, v, carry);
      clear_code();
      // Taken branch skips the 91h marker
      place_code(8'h00, 11, 128'({carry ? 8'hD3 : 8'hC3, 8'h74, v, cond, 8'h02,
                                  8'hF5, 8'h91, 8'hF5, 8'h90, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt(16'h0009, name);
      if (!taken) expect_write(8'h91, v);
      expect_write(8'h90, v);
      verify_writes(name);
    end
  endtask

  task automatic long_jump();
    logic [7:0] r;
    logic [7:0] v;
    logic [7:0] target;
    string      name;
    for (int i = 0; i < LJMP_RUNS; i++) begin
      random_byte(r);
      random_byte(v);
      target = 8'h10 + {2'b00, r[5:0]};
      name   = $sformatf("ljmp to %02h", target);
      clear_code();
      place_code(8'h00, 5, 128'({8'h02, 8'h00, target, 8'hF5, 8'h91}));
      place_code(target, 6, 128'({8'h74, v, 8'hF5, 8'h90, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt({8'h00, target + 8'd4}, name);
      expect_write(8'h90, v);
      verify_writes(name);
    end
  endtask

  task automatic sfr_read();
    logic [7:0] k;
    string      name;
    for (int i = 0; i < SFR_RUNS; i++) begin
      random_byte(k);
      name = $sformatf("sfr read 93h xor %02h", k);
      clear_code();
      place_code(8'h00, 8, 128'({8'hE5, 8'h93, 8'h64, k, 8'hF5, 8'h90, 8'h80, 8'hFE}));
      reset_core(name);
      run_to_halt(16'h0006, name);
      expect_write(8'h90, sfr_table[8'h93] ^ k);
      verify_writes(name);
    end
  endtask

  task automatic write_timing();
    logic [7:0] v;
    logic [7:0] w;
    int         gaps [4] = '{3, 3, 4, 3}; // Cycles per instruction, bytes plus one
    string      name;
    name = "write timing";
    random_byte(v);
    random_byte(w);
    clear_code();
    place_code(8'h00, 15, 128'({8'h74, v, 8'hF5, 8'h90, 8'hF5, 8'h91, 8'hF5, 8'h92,
                                8'h75, 8'h94, w, 8'hF5, 8'h95, 8'h80, 8'hFE}));
    reset_core(name);
    run_to_halt(16'h000D, name);
    if (wr_cycle.size() == 5) begin
      for (int i = 0; i < 4; i++) begin
        compare_value(name, $sformatf("gap before write %0d", i + 1), gaps[i],
                      wr_cycle[i + 1] - wr_cycle[i]);
      end
    end
    expect_write(8'h90, v);
    expect_write(8'h91, v);
    expect_write(8'h92, v);
    expect_write(8'h94, w);
    expect_write(8'h95, v);
    verify_writes(name);
  endtask

  initial begin
    restart     = 1'b0;
    lfsr        = LFSR_SEED;
    error_count = 0;
    check_count = 0;
    for (int a = 0; a < 256; a++) sfr_table[a[7:0]] = 8'(a * 37 + 11);
    for (int a = 0; a < 256; a++) code_mem[a[7:0]] = 8'h00;
    wait (reset_n === 1'b1);
    reset_behavior();
    arith_flags();
    logic_banks();
    djnz_loop();
    cond_branches();
    long_jump();
    sfr_read();
    write_timing();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 4
) (
  input  logic restart,
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Low at time zero and again on every restart request
  initial begin
    reset_n = 1'b0;
    forever begin
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset_n = 1'b1; // Release 1 ns after the edge
      @(posedge restart);
      reset_n = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/mcs51_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mcs51_core #(
  parameter int IRAM_SIZE = mcs51_pkg::IRAM_SIZE_DEFAULT
) (
  input  logic        clk,
  input  logic        reset_n,
  output logic [15:0] code_addr,
  input  logic [7:0]  code_rdata,
  output logic [7:0]  sfr_raddr,
  input  logic [7:0]  sfr_rdata,
  output logic [7:0]  sfr_waddr,
  output logic [7:0]  sfr_wdata,
  output logic        sfr_we
);
  import mcs51_pkg::*;

  logic [7:0] opcode;
  logic [7:0] op1;
  logic [7:0] op2;
  logic       exec;
  alu_op_t    alu_op;
  src_sel_t   src_sel;
  dst_sel_t   dst_sel;
  branch_t    branch;
  carry_op_t  carry_op;
  logic [2:0] reg_sel;
  logic [7:0] acc;
  logic [7:0] psw;
  logic [7:0] operand;
  logic [7:0] alu_result;
  logic       cy;
  logic       ac;
  logic       ov;
  logic       flags_valid;

  mcs51_fetch u_fetch (
    .clk        (clk),
    .reset_n    (reset_n),
    .code_addr  (code_addr),
    .code_rdata (code_rdata),
    .branch     (branch),
    .acc        (acc),
    .psw_cy     (psw[PSW_CY]),
    .alu_result (alu_result),
    .opcode     (opcode),
    .op1        (op1),
    .op2        (op2),
    .exec       (exec)
  );

  mcs51_decode u_decode (
    .opcode    (opcode),
    .op1       (op1),
    .alu_op    (alu_op),
    .src_sel   (src_sel),
    .dst_sel   (dst_sel),
    .branch    (branch),
    .carry_op  (carry_op),
    .reg_sel   (reg_sel),
    .sfr_raddr (sfr_raddr)
  );

  mcs51_alu u_alu (
    .alu_op      (alu_op),
    .acc         (acc),
    .operand     (operand),
    .carry_in    (psw[PSW_CY]),
    .alu_result  (alu_result),
    .cy          (cy),
    .ac          (ac),
    .ov          (ov),
    .flags_valid (flags_valid)
  );

  mcs51_data_regs #(
    .IRAM_SIZE (IRAM_SIZE)
  ) u_data_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .exec        (exec),
    .src_sel     (src_sel),
    .dst_sel     (dst_sel),
    .carry_op    (carry_op),
    .reg_sel     (reg_sel),
    .op1         (op1),
    .op2         (op2),
    .alu_result  (alu_result),
    .cy          (cy),
    .ac          (ac),
    .ov          (ov),
    .flags_valid (flags_valid),
    .acc         (acc),
    .psw         (psw),
    .operand     (operand),
    .sfr_rdata   (sfr_rdata),
    .sfr_waddr   (sfr_waddr),
    .sfr_wdata   (sfr_wdata),
    .sfr_we      (sfr_we)
  );

endmodule

`default_nettype wire

/* core/mcs51_data_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mcs51_data_regs #(
  parameter int IRAM_SIZE = 128
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 exec,
  input  mcs51_pkg::src_sel_t  src_sel,
  input  mcs51_pkg::dst_sel_t  dst_sel,
  input  mcs51_pkg::carry_op_t carry_op,
  input  logic [2:0]           reg_sel,
  input  logic [7:0]           op1,
  input  logic [7:0]           op2,
  input  logic [7:0]           alu_result,
  input  logic                 cy,
  input  logic                 ac,
  input  logic                 ov,
  input  logic                 flags_valid,
  output logic [7:0]           acc,
  output logic [7:0]           psw,
  output logic [7:0]           operand,
  input  logic [7:0]           sfr_rdata,
  output logic [7:0]           sfr_waddr,
  output logic [7:0]           sfr_wdata,
  output logic                 sfr_we
);
  import mcs51_pkg::*;

  localparam int AW = $clog2(IRAM_SIZE);

  logic [7:0] iram [IRAM_SIZE];
  logic [7:0] b_reg;
  logic [7:0] sp_reg;
  logic [7:0] reg_addr;
  logic [7:0] reg_rdata;
  logic [7:0] dir_rdata;
  logic [7:0] iram_waddr;
  logic [7:0] acc_next;
  logic [7:0] psw_next;
  logic       dir_wr;
  logic       int_sfr;
  logic       ext_wr;
  logic       iram_we;

  // Bank base from RS1:RS0, eight registers per bank
  assign reg_addr  = {3'b000, psw[PSW_RS1], psw[PSW_RS0], reg_sel};
  assign reg_rdata = (int'(reg_addr) < IRAM_SIZE) ? iram[reg_addr[AW-1:0]] : 8'h00;

  assign int_sfr = (op1 == SFR_ACC) || (op1 == SFR_B) || (op1 == SFR_PSW) || (op1 == SFR_SP);
  assign dir_wr  = exec && (dst_sel == DST_DIRECT);
  assign ext_wr  = dir_wr && op1[7] && !int_sfr;

  always_comb begin
    if (!op1[7]) begin
      dir_rdata = (int'(op1) < IRAM_SIZE) ? iram[op1[AW-1:0]] : 8'h00;
    end else begin
      case (op1)
        SFR_ACC: dir_rdata = acc;
        SFR_B:   dir_rdata = b_reg;
        SFR_PSW: dir_rdata = psw;
        SFR_SP:  dir_rdata = sp_reg;
        default: dir_rdata = sfr_rdata;
      endcase
    end
  end

  always_comb begin
    case (src_sel)
      SRC_IMM:    operand = (dst_sel == DST_DIRECT) ? op2 : op1; // MOV direct,#imm data
      SRC_REG:    operand = reg_rdata;
      SRC_DIRECT: operand = dir_rdata;
      default:    operand = acc;
    endcase
  end

  always_comb begin
    acc_next = acc;
    if (exec && (dst_sel == DST_ACC)) acc_next = alu_result;
    if (dir_wr && (op1 == SFR_ACC)) acc_next = alu_result;
    psw_next = psw;
    if (exec) begin
      if (flags_valid) begin
        psw_next[PSW_CY] = cy;
        psw_next[PSW_AC] = ac;
        psw_next[PSW_OV] = ov;
      end
      if (carry_op == CY_CLEAR) psw_next[PSW_CY] = 1'b0;
      if (carry_op == CY_SET) psw_next[PSW_CY] = 1'b1;
      if (dir_wr && (op1 == SFR_PSW)) psw_next = alu_result;
    end
    psw_next[PSW_P] = ^acc_next; // Odd parity always tracks ACC
  end

  always_comb begin
    iram_waddr = (dst_sel == DST_REG) ? reg_addr : op1;
    iram_we    = exec && ((dst_sel == DST_REG) || (dir_wr && !op1[7])) &&
                 (int'(iram_waddr) < IRAM_SIZE);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      acc    <= 8'h00;
      psw    <= 8'h00;
      b_reg  <= 8'h00;
      sp_reg <= SP_RESET;
      sfr_we <= 1'b0;
    end else begin
      acc    <= acc_next;
      psw    <= psw_next;
      sfr_we <= ext_wr;
      if (dir_wr && (op1 == SFR_B)) b_reg <= alu_result;
      if (dir_wr && (op1 == SFR_SP)) sp_reg <= alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (iram_we) iram[iram_waddr[AW-1:0]] <= alu_result;
    if (ext_wr) begin
      sfr_waddr <= op1;
      sfr_wdata <= alu_result;
    end
  end

  // External writes only reach addresses outside RAM and the core SFRs
  a_sfr_we_external: assert property (@(posedge clk) disable iff (!reset_n)
    sfr_we |-> sfr_waddr[7] && (sfr_waddr != SFR_ACC) && (sfr_waddr != SFR_B) &&
               (sfr_waddr != SFR_PSW) && (sfr_waddr != SFR_SP));

endmodule

`default_nettype wire

/* core/mcs51_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mcs51_alu (
  input  mcs51_pkg::alu_op_t alu_op,
  input  logic [7:0]         acc,
  input  logic [7:0]         operand,
  input  logic               carry_in,
  output logic [7:0]         alu_result,
  output logic               cy,
  output logic               ac,
  output logic               ov,
  output logic               flags_valid
);
  import mcs51_pkg::*;

  logic       cin;
  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] sum_lo;
  logic [4:0] diff_lo;

  assign cin     = (alu_op == ALU_ADD) ? 1'b0 : carry_in; // Plain ADD ignores CY
  assign sum     = {1'b0, acc} + {1'b0, operand} + {8'd0, cin};
  assign diff    = {1'b0, acc} - {1'b0, operand} - {8'd0, cin};
  assign sum_lo  = {1'b0, acc[3:0]} + {1'b0, operand[3:0]} + {4'd0, cin};
  assign diff_lo = {1'b0, acc[3:0]} - {1'b0, operand[3:0]} - {4'd0, cin};

  assign flags_valid = (alu_op == ALU_ADD) || (alu_op == ALU_ADDC) || (alu_op == ALU_SUBB);

  always_comb begin
    cy = 1'b0;
    ac = 1'b0;
    ov = 1'b0;
    case (alu_op)
      ALU_ADD, ALU_ADDC: begin
        alu_result = sum[7:0];
        cy         = sum[8];
        ac         = sum_lo[4];
        ov         = (acc[7] == operand[7]) && (sum[7] != acc[7]); // Same signs, sign flipped
      end
      ALU_SUBB: begin
        alu_result = diff[7:0];
        cy         = diff[8]; // Borrow out of bit 7
        ac         = diff_lo[4];
        ov         = (acc[7] ^ operand[7]) & (acc[7] ^ diff[7]);
      end
      ALU_AND: alu_result = acc & operand;
      ALU_OR:  alu_result = acc | operand;
      ALU_XOR: alu_result = acc ^ operand;
      ALU_INC: alu_result = operand + 8'd1;
      ALU_DEC: alu_result = operand - 8'd1;
      ALU_CPL: alu_result = ~operand;
      ALU_CLR: alu_result = 8'h00;
      default: alu_result = operand; // Moves
    endcase
  end

endmodule

`default_nettype wire

/* core/mcs51_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mcs51_decode (
  input  logic [7:0]           opcode,
  input  logic [7:0]           op1,
  output mcs51_pkg::alu_op_t   alu_op,
  output mcs51_pkg::src_sel_t  src_sel,
  output mcs51_pkg::dst_sel_t  dst_sel,
  output mcs51_pkg::branch_t   branch,
  output mcs51_pkg::carry_op_t carry_op,
  output logic [2:0]           reg_sel,
  output logic [7:0]           sfr_raddr
);
  import mcs51_pkg::*;

  assign reg_sel   = opcode[2:0];
  assign sfr_raddr = (src_sel == SRC_DIRECT) ? op1 : 8'h00;

  always_comb begin
    case (opcode) inside
      OP_MOV_A_IMM, OP_MOV_DIR_IMM, [OP_MOV_RN_IMM:OP_MOV_RN_IMM + 8'd7],
      OP_ADD_IMM, OP_ADDC_IMM, OP_SUBB_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM:
        src_sel = SRC_IMM;
      [OP_MOV_A_RN:OP_MOV_A_RN + 8'd7], [OP_INC_RN:OP_INC_RN + 8'd7],
      [OP_DJNZ_RN:OP_DJNZ_RN + 8'd7], [OP_ADD_RN:OP_ADD_RN + 8'd7],
      [OP_ADDC_RN:OP_ADDC_RN + 8'd7], [OP_SUBB_RN:OP_SUBB_RN + 8'd7],
      [OP_ANL_RN:OP_ANL_RN + 8'd7], [OP_ORL_RN:OP_ORL_RN + 8'd7],
      [OP_XRL_RN:OP_XRL_RN + 8'd7]:
        src_sel = SRC_REG;
      OP_MOV_A_DIR:
        src_sel = SRC_DIRECT;
      default:
        src_sel = SRC_NONE; // Operand is ACC
    endcase
  end

  always_comb begin
    case (opcode) inside
      OP_MOV_A_IMM, OP_MOV_A_DIR, OP_INC_A, OP_DEC_A, OP_CLR_A, OP_CPL_A,
      OP_ADD_IMM, OP_ADDC_IMM, OP_SUBB_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM,
      [OP_MOV_A_RN:OP_MOV_A_RN + 8'd7], [OP_ADD_RN:OP_ADD_RN + 8'd7],
      [OP_ADDC_RN:OP_ADDC_RN + 8'd7], [OP_SUBB_RN:OP_SUBB_RN + 8'd7],
      [OP_ANL_RN:OP_ANL_RN + 8'd7], [OP_ORL_RN:OP_ORL_RN + 8'd7],
      [OP_XRL_RN:OP_XRL_RN + 8'd7]:
        dst_sel = DST_ACC;
      [OP_MOV_RN_IMM:OP_MOV_RN_IMM + 8'd7], [OP_MOV_RN_A:OP_MOV_RN_A + 8'd7],
      [OP_INC_RN:OP_INC_RN + 8'd7], [OP_DJNZ_RN:OP_DJNZ_RN + 8'd7]:
        dst_sel = DST_REG;
      OP_MOV_DIR_A, OP_MOV_DIR_IMM:
        dst_sel = DST_DIRECT;
      default:
        dst_sel = DST_NONE;
    endcase
  end

  always_comb begin
    case (opcode) inside
      OP_ADD_IMM, [OP_ADD_RN:OP_ADD_RN + 8'd7]:    alu_op = ALU_ADD;
      OP_ADDC_IMM, [OP_ADDC_RN:OP_ADDC_RN + 8'd7]: alu_op = ALU_ADDC;
      OP_SUBB_IMM, [OP_SUBB_RN:OP_SUBB_RN + 8'd7]: alu_op = ALU_SUBB;
      OP_ANL_IMM, [OP_ANL_RN:OP_ANL_RN + 8'd7]:    alu_op = ALU_AND;
      OP_ORL_IMM, [OP_ORL_RN:OP_ORL_RN + 8'd7]:    alu_op = ALU_OR;
      OP_XRL_IMM, [OP_XRL_RN:OP_XRL_RN + 8'd7]:    alu_op = ALU_XOR;
      OP_INC_A, [OP_INC_RN:OP_INC_RN + 8'd7]:      alu_op = ALU_INC;
      OP_DEC_A, [OP_DJNZ_RN:OP_DJNZ_RN + 8'd7]:    alu_op = ALU_DEC; // DJNZ counts down
      OP_CPL_A:                                    alu_op = ALU_CPL;
      OP_CLR_A:                                    alu_op = ALU_CLR;
      default:                                     alu_op = ALU_PASS;
    endcase
  end

  always_comb begin
    case (opcode) inside
      OP_LJMP:                        branch = BR_LONG;
      OP_SJMP:                        branch = BR_SHORT;
      OP_JZ:                          branch = BR_JZ;
      OP_JNZ:                         branch = BR_JNZ;
      OP_JC:                          branch = BR_JC;
      OP_JNC:                         branch = BR_JNC;
      [OP_DJNZ_RN:OP_DJNZ_RN + 8'd7]: branch = BR_DJNZ;
      default:                        branch = BR_NONE;
    endcase
    case (opcode)
      OP_CLR_C:  carry_op = CY_CLEAR;
      OP_SETB_C: carry_op = CY_SET;
      default:   carry_op = CY_KEEP;
    endcase
  end

endmodule

`default_nettype wire

/* core/mcs51_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module mcs51_fetch (
  input  logic               clk,
  input  logic               reset_n,
  output logic [15:0]        code_addr,
  input  logic [7:0]         code_rdata,
  input  mcs51_pkg::branch_t branch,
  input  logic [7:0]         acc,
  input  logic               psw_cy,
  input  logic [7:0]         alu_result,
  output logic [7:0]         opcode,
  output logic [7:0]         op1,
  output logic [7:0]         op2,
  output logic               exec
);
  import mcs51_pkg::*;

  typedef enum logic [1:0] {S_FETCH, S_FETCH1, S_FETCH2, S_EXEC} state_t;

  state_t      state;
  logic [15:0] pc;
  logic [15:0] pc_seq;
  logic [15:0] pc_rel;
  logic [15:0] pc_next;
  logic [1:0]  instr_len;
  logic [1:0]  fetch_len;
  logic        taken;

  function automatic logic [1:0] op_length(input logic [7:0] op);
    case (op) inside
      OP_LJMP, OP_MOV_DIR_IMM:
        op_length = 2'd3;
      OP_MOV_A_IMM, OP_MOV_A_DIR, OP_MOV_DIR_A, OP_ADD_IMM, OP_ADDC_IMM,
      OP_SUBB_IMM, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM,
      OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC,
      [OP_MOV_RN_IMM:OP_MOV_RN_IMM + 8'd7], [OP_DJNZ_RN:OP_DJNZ_RN + 8'd7]:
        op_length = 2'd2;
      default:
        op_length = 2'd1; // Dropped opcodes run as NOP
    endcase
  endfunction

  assign code_addr = pc;
  assign exec      = (state == S_EXEC);
  assign fetch_len = op_length(code_rdata);

  // PC rests on the last instruction byte until EXEC
  assign pc_seq = pc + 16'd1;
  assign pc_rel = pc_seq + {{8{op1[7]}}, op1};

  always_comb begin
    case (branch)
      BR_SHORT: taken = 1'b1;
      BR_JZ:    taken = (acc == 8'h00);
      BR_JNZ:   taken = (acc != 8'h00);
      BR_JC:    taken = psw_cy;
      BR_JNC:   taken = !psw_cy;
      BR_DJNZ:  taken = (alu_result != 8'h00); // Count after decrement
      default:  taken = 1'b0;
    endcase
    if (branch == BR_LONG) begin
      pc_next = {op1, op2};
    end else if (taken) begin
      pc_next = pc_rel;
    end else begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= S_FETCH;
      pc        <= 16'h0000;
      opcode    <= OP_NOP;
      instr_len <= 2'd1;
    end else begin
      case (state)
        S_FETCH: begin
          opcode    <= code_rdata;
          instr_len <= fetch_len;
          if (fetch_len == 2'd1) begin
            state <= S_EXEC;
          end else begin
            pc    <= pc_seq;
            state <= S_FETCH1;
          end
        end
        S_FETCH1: begin
          if (instr_len == 2'd3) begin
            pc    <= pc_seq;
            state <= S_FETCH2;
          end else begin
            state <= S_EXEC;
          end
        end
        S_FETCH2: state <= S_EXEC;
        default: begin
          pc    <= pc_next;
          state <= S_FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH1) op1 <= code_rdata;
    if (state == S_FETCH2) op2 <= code_rdata;
  end

  // Every instruction returns to FETCH after one execute cycle
  a_exec_single: assert property (@(posedge clk) disable iff (!reset_n) exec |=> !exec);

endmodule

`default_nettype wire

/* common/mcs51_pkg.sv */
`default_nettype none

package mcs51_pkg;

  localparam int IRAM_SIZE_DEFAULT = 128;

  // Opcodes, Rn groups are given by their R0 member
  localparam logic [7:0] OP_NOP         = 8'h00;
  localparam logic [7:0] OP_LJMP        = 8'h02;
  localparam logic [7:0] OP_INC_A       = 8'h04;
  localparam logic [7:0] OP_INC_RN      = 8'h08;
  localparam logic [7:0] OP_DEC_A       = 8'h14;
  localparam logic [7:0] OP_ADD_IMM     = 8'h24;
  localparam logic [7:0] OP_ADD_RN      = 8'h28;
  localparam logic [7:0] OP_ADDC_IMM    = 8'h34;
  localparam logic [7:0] OP_ADDC_RN     = 8'h38;
  localparam logic [7:0] OP_JC          = 8'h40;
  localparam logic [7:0] OP_ORL_IMM     = 8'h44;
  localparam logic [7:0] OP_ORL_RN      = 8'h48;
  localparam logic [7:0] OP_JNC         = 8'h50;
  localparam logic [7:0] OP_ANL_IMM     = 8'h54;
  localparam logic [7:0] OP_ANL_RN      = 8'h58;
  localparam logic [7:0] OP_JZ          = 8'h60;
  localparam logic [7:0] OP_XRL_IMM     = 8'h64;
  localparam logic [7:0] OP_XRL_RN      = 8'h68;
  localparam logic [7:0] OP_JNZ         = 8'h70;
  localparam logic [7:0] OP_MOV_A_IMM   = 8'h74;
  localparam logic [7:0] OP_MOV_DIR_IMM = 8'h75;
  localparam logic [7:0] OP_MOV_RN_IMM  = 8'h78;
  localparam logic [7:0] OP_SJMP        = 8'h80;
  localparam logic [7:0] OP_SUBB_IMM    = 8'h94;
  localparam logic [7:0] OP_SUBB_RN     = 8'h98;
  localparam logic [7:0] OP_CLR_C       = 8'hC3;
  localparam logic [7:0] OP_SETB_C      = 8'hD3;
  localparam logic [7:0] OP_DJNZ_RN     = 8'hD8;
  localparam logic [7:0] OP_CLR_A       = 8'hE4;
  localparam logic [7:0] OP_MOV_A_DIR   = 8'hE5;
  localparam logic [7:0] OP_MOV_A_RN    = 8'hE8;
  localparam logic [7:0] OP_CPL_A       = 8'hF4;
  localparam logic [7:0] OP_MOV_DIR_A   = 8'hF5;
  localparam logic [7:0] OP_MOV_RN_A    = 8'hF8;

  // Internal SFR addresses
  localparam logic [7:0] SFR_SP  = 8'h81;
  localparam logic [7:0] SFR_PSW = 8'hD0;
  localparam logic [7:0] SFR_ACC = 8'hE0;
  localparam logic [7:0] SFR_B   = 8'hF0;

  localparam logic [7:0] SP_RESET = 8'h07;

  localparam int PSW_CY  = 7;
  localparam int PSW_AC  = 6;
  localparam int PSW_RS1 = 4;
  localparam int PSW_RS0 = 3;
  localparam int PSW_OV  = 2;
  localparam int PSW_P   = 0;

  typedef enum logic [3:0] {
    ALU_PASS, ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_INC, ALU_DEC, ALU_CPL, ALU_CLR
  } alu_op_t;

  typedef enum logic [1:0] {SRC_IMM, SRC_REG, SRC_DIRECT, SRC_NONE} src_sel_t;

  typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_REG, DST_DIRECT} dst_sel_t;

  typedef enum logic [2:0] {
    BR_NONE, BR_LONG, BR_SHORT, BR_JZ, BR_JNZ, BR_JC, BR_JNC, BR_DJNZ
  } branch_t;

  typedef enum logic [1:0] {CY_KEEP, CY_CLEAR, CY_SET} carry_op_t;

endpackage

`default_nettype wire
